/* source/icache_compare.sv */
`default_nettype none

`include "icache_defs.svh"

module icache_compare import icache_pkg::*; (
    input  wire logic           clk,
    input  wire logic           rst_n,
    icache_lookup_if.compare_mp lk,
    icache_refill_if.compare_mp rf,
    output logic [31:0]         fetch_rdata_o,
    output logic                fetch_valid_o,
    output logic                hit_way_o
);

    icache_status_e status_q;
    logic           hit0;
    logic           hit1;
    logic           hit;
    logic           axi_req;
    icache_addr_u   miss_addr;
    logic [31:0]    refill_word;
    logic [31:0]    read_data_q;

    function automatic logic [31:0] pick_word(
        input logic [`ICACHE_LINE_W-1:0]         line,
        input logic [$clog2(`ICACHE_WORDS)-1:0]  idx
    );
        pick_word = line[idx*32 +: 32];
    endfunction

    ////////////////////
    // hit compare
    ////////////////////
    assign hit0 = lk.tagv0.valid && (lk.tagv0.tag == lk.addr.f.tag);
    assign hit1 = lk.tagv1.valid && (lk.tagv1.tag == lk.addr.f.tag);
    assign hit  = hit0 | hit1;

    assign hit_way_o = hit1;

    // one request per miss; installing covers the stale tags
    // read in the cycle right after the line is written
    assign axi_req = lk.req && !hit && !rf.installing && (status_q == ICACHE_IDLE);

    always_comb begin
        miss_addr            = lk.addr;
        miss_addr.f.word     = '0;
        miss_addr.f.byte_sel = '0;
    end

    assign rf.axi_req   = axi_req;
    assign rf.miss_addr = miss_addr;

    ////////////////////
    // miss FSM
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_q <= ICACHE_IDLE;
        end else begin
            case (status_q)
                ICACHE_IDLE: if (axi_req) status_q <= ICACHE_READ;
                ICACHE_READ: if (rf.rend) status_q <= ICACHE_IDLE;
                default:     status_q <= ICACHE_IDLE;
            endcase
        end
    end

    // stall rises together with the request
    assign lk.stall = axi_req | (status_q == ICACHE_READ);

    // word of the returning line, kept for the completion cycle
    assign refill_word = pick_word(rf.line, lk.addr.f.word);

    always_ff @(posedge clk) begin
        if ((status_q == ICACHE_READ) && rf.rend) begin
            read_data_q <= refill_word;
        end
    end

    ////////////////////
    // to cpu
    ////////////////////
    assign fetch_rdata_o = hit0 ? pick_word(lk.data0, lk.addr.f.word) :
                           hit1 ? pick_word(lk.data1, lk.addr.f.word) :
                           read_data_q;

    assign fetch_valid_o = lk.req && (hit || rf.installing);

endmodule

`default_nettype wire

/* source/icache_defs.svh */
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// address split, 21 + 6 + 3 + 2 bits
`define ICACHE_TAG_W    21
`define ICACHE_INDEX_W  6

// number of sets per way
`define ICACHE_SETS     64

// line geometry, eight 32-bit words
`define ICACHE_WORDS    8
`define ICACHE_LINE_W   256

`endif

/* source/icache_ifs.sv */
`default_nettype none

`include "icache_defs.svh"

////////////////////
// lookup stage toward compare and install
////////////////////
interface icache_lookup_if import icache_pkg::*; ();

    logic                      req;
    icache_addr_u              addr;
    icache_tagv_t              tagv0;
    icache_tagv_t              tagv1;
    logic [`ICACHE_LINE_W-1:0] data0;
    logic [`ICACHE_LINE_W-1:0] data1;
    logic                      stall;

    modport lookup_mp (
        output req, addr, tagv0, tagv1, data0, data1,
        input  stall
    );

    modport compare_mp (
        input  req, addr, tagv0, tagv1, data0, data1,
        output stall
    );

    // lru update on hits only needs the fetch itself
    modport install_mp (
        input req, addr
    );

endinterface

////////////////////
// refill bus side
////////////////////
interface icache_refill_if import icache_pkg::*; ();

    icache_addr_u              miss_addr;
    logic                      axi_req;
    logic                      rend;
    logic [`ICACHE_LINE_W-1:0] line;
    logic                      installing;

    modport compare_mp (
        output miss_addr, axi_req,
        input  rend, line, installing
    );

    modport install_mp (
        input  miss_addr, rend, line,
        output installing
    );

endinterface

`default_nettype wire

/* source/icache_install.sv */
`default_nettype none

`include "icache_defs.svh"

module icache_install import icache_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    icache_lookup_if.install_mp        lk,
    icache_refill_if.install_mp        rf,
    input  wire logic                  hit_way_i,
    input  wire logic                  hit_i,
    output logic                       wr_en_o,
    output logic                       wr_way_o,
    output logic [`ICACHE_INDEX_W-1:0] wr_index_o,
    output icache_tagv_t               wr_tagv_o,
    output logic [`ICACHE_LINE_W-1:0]  wr_line_o
);

    // one bit per set, names the victim way
    logic [`ICACHE_SETS-1:0] lru_q;
    logic                    installing_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_q        <= '0;
            installing_q <= 1'b0;
        end else begin
            installing_q <= rf.rend;
            if (rf.rend) begin
                lru_q[rf.miss_addr.f.index] <= ~lru_q[rf.miss_addr.f.index];
            end else if (lk.req && hit_i && !installing_q) begin
                // the completion cycle is not a real hit
                lru_q[lk.addr.f.index] <= ~hit_way_i;
            end
        end
    end

    ////////////////////
    // line write into the victim
    ////////////////////
    assign wr_en_o    = rf.rend;
    assign wr_way_o   = lru_q[rf.miss_addr.f.index];
    assign wr_index_o = rf.miss_addr.f.index;
    assign wr_tagv_o  = '{valid: 1'b1, tag: rf.miss_addr.f.tag};
    assign wr_line_o  = rf.line;

    assign rf.installing = installing_q;

endmodule

`default_nettype wire

/* source/icache_lookup.sv */
`default_nettype none

`include "icache_defs.svh"

module icache_lookup import icache_pkg::*; (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       fetch_req_i,
    input  icache_addr_u                    fetch_addr_i,
    output logic [`ICACHE_INDEX_W-1:0]      rd_index_o,
    icache_lookup_if.lookup_mp              lk,
    input  icache_tagv_t                    rd_tagv0_i,
    input  icache_tagv_t                    rd_tagv1_i,
    input  wire logic [`ICACHE_LINE_W-1:0]  rd_line0_i,
    input  wire logic [`ICACHE_LINE_W-1:0]  rd_line1_i
);

    logic         req_q;
    icache_addr_u addr_q;

    // accept a new fetch only when compare is not stalling
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else if (!lk.stall) begin
            req_q <= fetch_req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!lk.stall && fetch_req_i) begin
            addr_q <= fetch_addr_i;
        end
    end

    // under stall keep reading the held set,
    // so tags reflect the install write once it lands
    assign rd_index_o = lk.stall ? addr_q.f.index : fetch_addr_i.f.index;

    ////////////////////
    // toward compare
    ////////////////////
    assign lk.req   = req_q;
    assign lk.addr  = addr_q;
    assign lk.tagv0 = rd_tagv0_i;
    assign lk.tagv1 = rd_tagv1_i;
    assign lk.data0 = rd_line0_i;
    assign lk.data1 = rd_line1_i;

endmodule

`default_nettype wire

/* source/icache_pkg.sv */
`default_nettype none

`include "icache_defs.svh"

package icache_pkg;

    // fetch address, as a raw word or split into fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [`ICACHE_TAG_W-1:0]          tag;
            logic [`ICACHE_INDEX_W-1:0]        index;
            logic [$clog2(`ICACHE_WORDS)-1:0]  word;
            logic [1:0]                        byte_sel;
        } f;
    } icache_addr_u;

    typedef enum logic {
        ICACHE_IDLE,
        ICACHE_READ
    } icache_status_e;

    typedef struct packed {
        logic                     valid;
        logic [`ICACHE_TAG_W-1:0] tag;
    } icache_tagv_t;

endpackage

`default_nettype wire

/* source/icache_top.sv */
`default_nettype none

`include "icache_defs.svh"

module icache_top import icache_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    // cpu fetch port
    input  wire logic                      fetch_req_i,
    input  wire logic [31:0]               fetch_addr_i,
    output logic [31:0]                    fetch_rdata_o,
    output logic                           fetch_valid_o,
    output logic                           stall_o,
    // line refill bus
    output logic                           axi_req_o,
    output logic [31:0]                    axi_addr_o,
    input  wire logic                      axi_rend_i,
    input  wire logic [`ICACHE_LINE_W-1:0] axi_line_i
);

    logic [`ICACHE_INDEX_W-1:0] rd_index;
    icache_tagv_t               rd_tagv0;
    icache_tagv_t               rd_tagv1;
    logic [`ICACHE_LINE_W-1:0]  rd_line0;
    logic [`ICACHE_LINE_W-1:0]  rd_line1;
    logic                       wr_en;
    logic                       wr_way;
    logic [`ICACHE_INDEX_W-1:0] wr_index;
    icache_tagv_t               wr_tagv;
    logic [`ICACHE_LINE_W-1:0]  wr_line;
    logic                       hit_way;

    icache_lookup_if lk_if ();
    icache_refill_if rf_if ();

    assign rf_if.rend = axi_rend_i;
    assign rf_if.line = axi_line_i;
    assign axi_req_o  = rf_if.axi_req;
    assign axi_addr_o = rf_if.miss_addr.raw;
    assign stall_o    = lk_if.stall;

    icache_ways u_ways (
        .clk, .rst_n,
        .rd_index_i (rd_index), .rd_tagv0_o (rd_tagv0), .rd_tagv1_o (rd_tagv1),
        .rd_line0_o (rd_line0), .rd_line1_o (rd_line1),
        .wr_en_i (wr_en), .wr_way_i (wr_way), .wr_index_i (wr_index),
        .wr_tagv_i (wr_tagv), .wr_line_i (wr_line)
    );

    icache_lookup u_lookup (
        .clk, .rst_n, .fetch_req_i, .fetch_addr_i,
        .rd_index_o (rd_index), .lk (lk_if),
        .rd_tagv0_i (rd_tagv0), .rd_tagv1_i (rd_tagv1),
        .rd_line0_i (rd_line0), .rd_line1_i (rd_line1)
    );

    icache_compare u_compare (
        .clk, .rst_n, .lk (lk_if), .rf (rf_if),
        .fetch_rdata_o, .fetch_valid_o, .hit_way_o (hit_way)
    );

    // a valid fetch outside the install cycle is a hit
    icache_install u_install (
        .clk, .rst_n, .lk (lk_if), .rf (rf_if),
        .hit_way_i (hit_way), .hit_i (fetch_valid_o),
        .wr_en_o (wr_en), .wr_way_o (wr_way), .wr_index_o (wr_index),
        .wr_tagv_o (wr_tagv), .wr_line_o (wr_line)
    );

endmodule

`default_nettype wire

/* source/icache_ways.sv */
`default_nettype none

`include "icache_defs.svh"

module icache_ways import icache_pkg::*; (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [`ICACHE_INDEX_W-1:0] rd_index_i,
    output icache_tagv_t                    rd_tagv0_o,
    output icache_tagv_t                    rd_tagv1_o,
    output logic [`ICACHE_LINE_W-1:0]       rd_line0_o,
    output logic [`ICACHE_LINE_W-1:0]       rd_line1_o,
    input  wire logic                       wr_en_i,
    input  wire logic                       wr_way_i,
    input  wire logic [`ICACHE_INDEX_W-1:0] wr_index_i,
    input  icache_tagv_t                    wr_tagv_i,
    input  wire logic [`ICACHE_LINE_W-1:0]  wr_line_i
);

    logic [`ICACHE_SETS-1:0]   valid_q  [2];
    logic [`ICACHE_TAG_W-1:0]  tag_mem  [2][`ICACHE_SETS];
    logic [`ICACHE_LINE_W-1:0] line_mem [2][`ICACHE_SETS];
    icache_tagv_t              rd_tagv_q [2];
    logic [`ICACHE_LINE_W-1:0] rd_line_q [2];

    // valid bits are the only state cleared by reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_way_i][wr_index_i] <= wr_tagv_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[wr_way_i][wr_index_i]  <= wr_tagv_i.tag;
            line_mem[wr_way_i][wr_index_i] <= wr_line_i;
        end
    end

    // synchronous read, a same-edge write is seen next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_tagv_q[0] <= '0;
            rd_tagv_q[1] <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                rd_tagv_q[w] <= '{valid: valid_q[w][rd_index_i], tag: tag_mem[w][rd_index_i]};
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            rd_line_q[w] <= line_mem[w][rd_index_i];
        end
    end

    assign rd_tagv0_o = rd_tagv_q[0];
    assign rd_tagv1_o = rd_tagv_q[1];
    assign rd_line0_o = rd_line_q[0];
    assign rd_line1_o = rd_line_q[1];

endmodule

`default_nettype wire

/* tb.f */
+incdir+source
source/icache_pkg.sv
source/icache_ifs.sv
source/icache_ways.sv
source/icache_lookup.sv
source/icache_compare.sv
source/icache_install.sv
source/icache_top.sv
tests/icache_chk.sv
tests/icache_tb.sv

/* tests/icache_chk.sv */
`default_nettype none

module icache_chk import icache_pkg::*; (
    input wire logic        clk,
    input wire logic        rst_n,
    input wire logic        axi_req_i,
    input wire logic [31:0] axi_addr_i,
    input wire logic        axi_rend_i,
    input wire logic        stall_i,
    input wire logic        fetch_valid_i,
    input icache_status_e   status_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    // refill request is a one-cycle pulse
    req_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        axi_req_i |=> !axi_req_i)
    else begin
        fail_count++;
        $error("refill request lasted more than one cycle");
    end

    // never a second request while a refill is outstanding
    req_not_in_read: assert property (@(posedge clk) disable iff (!rst_n)
        !(axi_req_i && status_i == ICACHE_READ))
    else begin
        fail_count++;
        $error("refill request raised in ICACHE_READ");
    end

    req_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        axi_req_i |-> axi_addr_i[4:0] == 5'b0)
    else begin
        fail_count++;
        $error("refill address not line aligned");
    end

    // stall comes up in the same cycle as the request
    stall_with_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(axi_req_i) |-> $rose(stall_i))
    else begin
        fail_count++;
        $error("stall did not rise together with the refill request");
    end

    // released only in the cycle after rend
    stall_until_rend: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(stall_i) |-> $past(axi_rend_i))
    else begin
        fail_count++;
        $error("stall released other than in the cycle after rend");
    end

    no_valid_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !fetch_valid_i)
    else begin
        fail_count++;
        $error("fetch valid high in the first cycle after reset");
    end

endmodule

bind icache_top icache_chk u_chk (
    .clk,
    .rst_n,
    .axi_req_i     (axi_req_o),
    .axi_addr_i    (axi_addr_o),
    .axi_rend_i,
    .stall_i       (stall_o),
    .fetch_valid_i (fetch_valid_o),
    .status_i      (u_compare.status_q)
);

`default_nettype wire

/* tests/icache_tb.sv */
`default_nettype none

`include "icache_defs.svh"

module icache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] MEM_KEY    = 32'h5a5a_0000;
    localparam int          WAIT_LIMIT = 50;

    logic                      clk;
    logic                      rst_n;
    logic                      fetch_req_i;
    logic [31:0]               fetch_addr_i;
    logic [31:0]               fetch_rdata_o;
    logic                      fetch_valid_o;
    logic                      stall_o;
    logic                      axi_req_o;
    logic [31:0]               axi_addr_o;
    logic                      axi_rend_i = 1'b0;
    logic [`ICACHE_LINE_W-1:0] axi_line_i = '0;

    int          checks = 0;
    int          errors = 0;
    int          req_count = 0;
    int          delay;
    logic        busy;
    logic [31:0] line_addr;
    logic [31:0] lfsr_q = 32'h9e4f_f68f;

    icache_top uut (
        .clk, .rst_n, .fetch_req_i, .fetch_addr_i, .fetch_rdata_o, .fetch_valid_o,
        .stall_o, .axi_req_o, .axi_addr_o, .axi_rend_i, .axi_line_i
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////
    // galois lfsr stepped once per bit taken
    function automatic int draw_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    // word w holds its own byte address xor the key
    function automatic logic [`ICACHE_LINE_W-1:0] make_line(input logic [31:0] base);
        logic [`ICACHE_LINE_W-1:0] l;
        for (int w = 0; w < `ICACHE_WORDS; w++) begin
            l[w*32 +: 32] = (base + 32'(4 * w)) ^ MEM_KEY;
        end
        return l;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // CPU holds the fetch until it is delivered
    task automatic fetch(input string name, input logic [31:0] addr, input bit exp_miss);
        int reqs0;
        int lat;
        reqs0 = req_count;
        @(negedge clk);
        check_value({name, " stall before fetch"}, 0, stall_o);
        fetch_req_i  = 1'b1;
        fetch_addr_i = addr;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!fetch_valid_o && lat < WAIT_LIMIT);
        fetch_req_i = 1'b0;
        checks++;
        assert (fetch_valid_o) else begin
            errors++;
            $display("fetch %s got no response within %0d cycles", name, WAIT_LIMIT);
        end
        if (fetch_valid_o) begin
            check_value({name, " data"}, addr ^ MEM_KEY, fetch_rdata_o);
            if (!exp_miss) begin
                check_value({name, " hit latency"}, 1, lat);
            end
            @(negedge clk);
            check_value({name, " single delivery"}, 0, fetch_valid_o);
            // the delivery cycle has been counted by now
            check_value({name, " requests"}, 32'(exp_miss), req_count - reqs0);
        end
    endtask

    // one new fetch per cycle and every one of them hits
    task automatic stream_hits(input string name, input logic [31:0] base, input int n);
        int          reqs0;
        logic [31:0] addr;
        reqs0 = req_count;
        for (int i = 0; i < n; i++) begin
            addr         = base + 32'(4 * i);
            fetch_req_i  = 1'b1;
            fetch_addr_i = addr;
            @(negedge clk);
            check_value($sformatf("%s valid %0d", name, i), 1, fetch_valid_o);
            check_value($sformatf("%s data %0d", name, i), addr ^ MEM_KEY, fetch_rdata_o);
        end
        fetch_req_i = 1'b0;
        @(negedge clk);
        check_value({name, " requests"}, 0, req_count - reqs0);
    endtask

    ////////////////////
    // bus responder
    ////////////////////
    always @(negedge clk) begin
        axi_rend_i = 1'b0;
        if (!rst_n) begin
            busy = 1'b0;
        end else if (busy) begin
            delay--;
            if (delay == 0) begin
                busy       = 1'b0;
                axi_rend_i = 1'b1;
                axi_line_i = make_line(line_addr);
            end
        end else if (axi_req_o) begin
            req_count++;
            line_addr = axi_addr_o;
            delay     = 1 + draw_bits(3);
            busy      = 1'b1;
        end
    end

    ////////////////////
    // test sequence
    ////////////////////
    initial begin
        logic [31:0] a;
        fetch_req_i  = 1'b0;
        fetch_addr_i = '0;
        rst_n        = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("reset stall", 0, stall_o);
        check_value("reset request", 0, axi_req_o);
        check_value("reset valid", 0, fetch_valid_o);
        fetch("first fetch", 32'h0000_0100, 1'b1);

        // misses over several sets and then another word of each line
        for (int i = 0; i < 4; i++) begin
            a = 32'h0004_0000 + 32'(i) * 32'h0000_0460;
            fetch($sformatf("miss %0d", i), a, 1'b1);
            fetch($sformatf("hit %0d", i), {a[31:5], 5'h1c}, 1'b0);
        end

        // three lines on set 2 where C evicts the LRU line B
        fetch("way A fill", 32'h0000_1040, 1'b1);
        fetch("way B fill", 32'h0001_1044, 1'b1);
        fetch("way B hit", 32'h0001_1048, 1'b0);
        fetch("way A hit", 32'h0000_104c, 1'b0);
        fetch("way C fill", 32'h0002_1050, 1'b1);
        fetch("way A kept", 32'h0000_1054, 1'b0);
        fetch("way B refetch", 32'h0001_1058, 1'b1);
        fetch("way A still", 32'h0000_105c, 1'b0);

        fetch("held miss", 32'h0003_0a08, 1'b1);
        stream_hits("stream", 32'h0003_0a00, 8);

        repeat (4) @(negedge clk);
        $display("checks %0d, failed %0d, assertion failures %0d",
                 checks, errors, uut.u_chk.fail_count);
        if (errors == 0 && uut.u_chk.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
